//--- src/fir_pkg.sv
package fir_pkg;

  // input sample width, unsigned
  localparam int sample_w = 8;

  // filter length and mirrored pair count
  localparam int taps  = 16;
  localparam int pairs = taps / 2;

  // pair sum carries one extra bit for the add
  localparam int pair_w = sample_w + 1;

  // signed coefficient width
  localparam int coef_w = 8;

  // product and output widths, both signed
  localparam int prod_w = 17;
  localparam int out_w  = 20;

  // cycles through one multiply tap
  localparam int mac_lat = 1;

  // accepted en edge to valid
  localparam int fir_lat = 4;

  // symmetric low-pass coefficients
  // pair k combines sample ages k and taps-1-k
  localparam logic signed [coef_w-1:0] coef_table [pairs] = '{
    -8'sd1,
    -8'sd1,
    8'sd2,
    8'sd3,
    -8'sd6,
    -8'sd9,
    8'sd19,
    8'sd56
  };

  // datapath payload types
  typedef logic [sample_w-1:0]      sample_t;
  typedef logic [pair_w-1:0]        pair_sum_t;
  typedef logic signed [prod_w-1:0] product_t;
  typedef logic signed [out_w-1:0]  yout_t;

endpackage

//--- src/tap_delay_line.sv
module tap_delay_line (
  input  logic                clk,
  input  logic                rstn,
  input  logic                en,
  input  fir_pkg::sample_t    xin,
  output fir_pkg::pair_sum_t  pair_sum [fir_pkg::pairs],
  output logic                pre_valid
);

  import fir_pkg::*;

  // sample history, index is the sample age
  // entry 0 holds the newest sample
  sample_t hist [taps];

  // en delayed by one cycle
  // marks a freshly shifted history
  logic en_d;

  // shift register of the last taps samples
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < taps; i++) begin
        hist[i] <= '0;
      end
    end else if (en) begin
      // newest sample enters at age 0
      hist[0] <= xin;
      for (int i = 1; i < taps; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  // first valid stage
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      en_d <= 1'b0;
    end else begin
      en_d <= en;
    end
  end

  // mirrored pre-adders
  // one cycle after the shift, so the new sample is already in hist
  always_ff @(posedge clk) begin
    if (en_d) begin
      for (int k = 0; k < pairs; k++) begin
        // zero-extend both ages before the add, no wrap
        pair_sum[k] <= pair_w'(hist[k]) + pair_w'(hist[taps-1-k]);
      end
    end
  end

  // pair sums qualified one cycle after the shift
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pre_valid <= 1'b0;
    end else begin
      // single-cycle pulse per accepted sample
      pre_valid <= en_d;
    end
  end

endmodule

//--- src/mac_tap.sv
module mac_tap #(
  parameter int tap_idx = 0
) (
  input  logic                clk,
  input  logic                rstn,
  input  logic                ce,
  input  fir_pkg::pair_sum_t  pair_sum,
  output fir_pkg::product_t   product
);

  import fir_pkg::*;

  // this tap's fixed coefficient
  logic signed [coef_w-1:0] coef;

  // operands widened to the product width
  logic signed [prod_w-1:0] pair_ext;
  logic signed [prod_w-1:0] coef_ext;

  assign coef = coef_table[tap_idx];

  // pair sum is unsigned, so zero-extend
  assign pair_ext = {{(prod_w-pair_w){1'b0}}, pair_sum};

  // coefficient is signed, so sign-extend
  assign coef_ext = {{(prod_w-coef_w){coef[coef_w-1]}}, coef};

  // registered multiply
  // largest magnitude is 56 * 510, well inside prod_w
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      product <= '0;
    end else if (ce) begin
      product <= pair_ext * coef_ext;
    end
  end

endmodule

//--- src/adder_tree.sv
module adder_tree (
  input  logic               clk,
  input  logic               rstn,
  input  logic               pre_valid,
  input  fir_pkg::product_t  product [fir_pkg::pairs],
  output logic               valid,
  output fir_pkg::yout_t     yout
);

  import fir_pkg::*;

  // valid pipeline, one bit per registered stage
  // bit mac_lat-1 qualifies the products
  // next bit the half sums, last bit yout
  logic [fir_lat-2:0] vld_pipe;

  // combinational half sums
  yout_t lo_sum;
  yout_t hi_sum;

  // registered half sums
  yout_t lo_sum_q;
  yout_t hi_sum_q;

  // valid shift register
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[fir_lat-3:0], pre_valid};
    end
  end

  // sum of the low and high product halves
  // each product sign-extended to the output width
  always_comb begin
    lo_sum = '0;
    hi_sum = '0;
    for (int i = 0; i < pairs / 2; i++) begin
      lo_sum = lo_sum + yout_t'(product[i]);
      hi_sum = hi_sum + yout_t'(product[i + pairs / 2]);
    end
  end

  // first stage, enabled by the product valid bit
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lo_sum_q <= '0;
      hi_sum_q <= '0;
    end else if (vld_pipe[mac_lat-1]) begin
      lo_sum_q <= lo_sum;
      hi_sum_q <= hi_sum;
    end
  end

  // final stage
  // yout holds between valid pulses
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      yout <= '0;
    end else if (vld_pipe[mac_lat]) begin
      yout <= lo_sum_q + hi_sum_q;
    end
  end

  // last pipeline bit lines up with yout
  assign valid = vld_pipe[fir_lat-2];

endmodule

//--- src/fir_top.sv
module fir_top (
  input  logic              clk,
  input  logic              rstn,
  input  logic              en,
  input  fir_pkg::sample_t  xin,
  output logic              valid,
  output fir_pkg::yout_t    yout
);

  import fir_pkg::*;

  // mirrored pair sums from the delay line
  pair_sum_t pair_sum [pairs];

  // pair sums valid, one pulse per sample
  logic pre_valid;

  // one product per pair
  product_t product [pairs];

  // history and pre-adders
  tap_delay_line tap_delay_line_inst (
    .clk       (clk),
    .rstn      (rstn),
    .en        (en),
    .xin       (xin),
    .pair_sum  (pair_sum),
    .pre_valid (pre_valid)
  );

  // eight multiply taps
  // all share pre_valid as clock enable
  for (genvar k = 0; k < pairs; k++) begin : gen_tap
    mac_tap #(
      .tap_idx (k)
    ) mac_tap_inst (
      .clk      (clk),
      .rstn     (rstn),
      .ce       (pre_valid),
      .pair_sum (pair_sum[k]),
      .product  (product[k])
    );
  end

  // two-stage sum and output valid
  // pre_valid delayed inside by mac_lat
  adder_tree adder_tree_inst (
    .clk       (clk),
    .rstn      (rstn),
    .pre_valid (pre_valid),
    .product   (product),
    .valid     (valid),
    .yout      (yout)
  );

endmodule

//--- verif/fir_checker.sv
module fir_checker (
  input  logic            clk,
  input  logic            rstn,
  input  logic            en,
  input  logic            valid,
  input  fir_pkg::yout_t  yout
);

  import fir_pkg::*;

  // number of assertion failures so far
  int fail_count;

  // one output pulse fir_lat edges after each accepting edge
  // and no pulse anywhere else
  // valid set at edge E+fir_lat is first sampled one edge later
  latency_check: assert property (
    @(posedge clk) disable iff (!rstn)
    valid == $past(en & rstn, fir_lat + 1)
  ) else begin
    $error("valid not aligned %0d cycles after an accepted en", fir_lat);
    fail_count++;
  end

  // reset keeps the output strobe low
  reset_idle_check: assert property (
    @(posedge clk) !rstn |-> !valid
  ) else begin
    $error("valid high while reset is asserted");
    fail_count++;
  end

  // output register holds between strobes
  hold_check: assert property (
    @(posedge clk) disable iff (!rstn)
    !valid |-> $stable(yout)
  ) else begin
    $error("yout changed while valid was low");
    fail_count++;
  end

endmodule

//--- verif/fir_scoreboard.sv
module fir_scoreboard (
  input  logic            clk,
  input  logic            rstn,
  input  logic            valid,
  input  fir_pkg::yout_t  yout,
  input  logic            exp_push,
  input  fir_pkg::yout_t  exp_val,
  input  int              test_id,
  input  logic            close,
  output int              pending,
  output int              pass_cnt,
  output int              fail_cnt
);

  import fir_pkg::*;

  // expected outputs, oldest first
  yout_t exp_q [$];

  // per-test tallies
  int n_checked;
  int n_errs;

  // totals over the run
  int n_pass;
  int n_fail;

  // value popped for the current compare
  yout_t exp_v;

  function automatic string test_name(input int id);
    case (id)
      0: return "impulse";
      1: return "step";
      2: return "random_gaps";
      3: return "back_to_back";
      4: return "reset_midstream";
      default: return "unknown";
    endcase
  endfunction

  always @(posedge clk) begin
    if (!rstn) begin
      // samples in flight are lost with the pipeline
      exp_q.delete();
    end else begin
      // push lines up with the edge where the DUT takes the sample
      if (exp_push) begin
        exp_q.push_back(exp_val);
      end
      if (valid) begin
        if (exp_q.size() == 0) begin
          $display("test %s: output %0d appeared with no sample outstanding",
                   test_name(test_id), yout);
          n_errs++;
        end else begin
          exp_v = exp_q.pop_front();
          n_checked++;
          if (yout !== exp_v) begin
            $display("ERR %s: expected %0d, actual %0d", test_name(test_id), exp_v, yout);
            n_errs++;
          end
        end
      end
    end

    // test boundary from the stimulus side
    if (close) begin
      if (exp_q.size() != 0) begin
        $display("test %s: %0d expected outputs never appeared",
                 test_name(test_id), exp_q.size());
        n_errs++;
        exp_q.delete();
      end
      if (n_errs == 0) begin
        $display("test %s: passed, %0d outputs checked", test_name(test_id), n_checked);
        n_pass++;
      end else begin
        $display("test %s: failed with %0d errors, %0d outputs checked",
                 test_name(test_id), n_errs, n_checked);
        n_fail++;
      end
      n_errs    = 0;
      n_checked = 0;
    end

    // status back to the stimulus process
    pending  <= exp_q.size();
    pass_cnt <= n_pass;
    fail_cnt <= n_fail;
  end

endmodule

//--- verif/fir_tb.sv
module fir_tb;

  import fir_pkg::*;

  localparam int n_tests     = 5;
  localparam int drain_limit = 100;

  // DUT ports
  logic    clk;
  logic    rstn;
  logic    en;
  sample_t xin;
  logic    valid;
  yout_t   yout;

  // expected values toward the scoreboard
  logic  exp_push;
  yout_t exp_val;
  int    test_id;
  logic  close;

  // scoreboard status
  int pending;
  int pass_cnt;
  int fail_cnt;

  int seed = 32'hdb19;

  // reference history, index is the sample age
  sample_t ref_hist [taps];

  fir_top fir_top_inst (
    .clk   (clk),
    .rstn  (rstn),
    .en    (en),
    .xin   (xin),
    .valid (valid),
    .yout  (yout)
  );

  fir_scoreboard fir_scoreboard_inst (
    .clk      (clk),
    .rstn     (rstn),
    .valid    (valid),
    .yout     (yout),
    .exp_push (exp_push),
    .exp_val  (exp_val),
    .test_id  (test_id),
    .close    (close),
    .pending  (pending),
    .pass_cnt (pass_cnt),
    .fail_cnt (fail_cnt)
  );

  // timing assertions on the DUT boundary
  bind fir_top fir_checker fir_checker_inst (
    .clk   (clk),
    .rstn  (rstn),
    .en    (en),
    .valid (valid),
    .yout  (yout)
  );

  always #5 clk = ~clk;

  function automatic void clear_history();
    for (int i = 0; i < taps; i++) begin
      ref_hist[i] = '0;
    end
  endfunction

  // shift in one sample, then sum coefficient times mirrored pair
  function automatic yout_t fir_ref(input sample_t x);
    yout_t acc;
    for (int i = taps - 1; i > 0; i--) begin
      ref_hist[i] = ref_hist[i-1];
    end
    ref_hist[0] = x;
    acc = '0;
    for (int k = 0; k < pairs; k++) begin
      acc = acc + yout_t'(coef_table[k])
                * (yout_t'(ref_hist[k]) + yout_t'(ref_hist[taps-1-k]));
    end
    return acc;
  endfunction

  task automatic drive_sample(input sample_t x);
    @(posedge clk);
    en       <= 1'b1;
    xin      <= x;
    exp_push <= 1'b1;
    exp_val  <= fir_ref(x);
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      en       <= 1'b0;
      exp_push <= 1'b0;
    end
  endtask

  // idle until every expected output is consumed, bounded
  task automatic wait_drain();
    int cycles;
    cycles = 0;
    drive_idle(1);
    while (cycles < drain_limit) begin
      @(posedge clk);
      if (pending == 0) begin
        break;
      end
      cycles++;
    end
    if (cycles == drain_limit) begin
      $display("timeout: %0d outputs still missing after %0d cycles", pending, drain_limit);
    end
  endtask

  task automatic start_test(input int id);
    @(posedge clk);
    test_id <= id;
  endtask

  task automatic close_test();
    @(posedge clk);
    close <= 1'b1;
    @(posedge clk);
    close <= 1'b0;
  endtask

  // single 1 then zeros, walks the coefficients through both ages
  task automatic run_impulse();
    drive_sample(8'd1);
    repeat (taps - 1) drive_sample(8'd0);
  endtask

  initial begin
    int gap;
    int asrt_fails;

    clk      = 1'b0;
    rstn     = 1'b0;
    en       = 1'b0;
    xin      = '0;
    exp_push = 1'b0;
    exp_val  = '0;
    test_id  = 0;
    close    = 1'b0;
    clear_history();
    repeat (8) @(posedge clk);
    rstn <= 1'b1;

    start_test(0);
    run_impulse();
    wait_drain();
    close_test();

    // ramps up, settles at 10 times twice the coefficient sum
    start_test(1);
    repeat (24) drive_sample(8'd10);
    wait_drain();
    close_test();

    start_test(2);
    for (int i = 0; i < 40; i++) begin
      gap = {$random(seed)} % 4;
      drive_idle(gap);
      drive_sample(sample_t'($random(seed)));
    end
    wait_drain();
    close_test();

    // full-scale swings, largest sums the datapath sees
    start_test(3);
    for (int i = 0; i < 16; i++) begin
      drive_sample((i % 2 == 0) ? 8'd255 : 8'd0);
    end
    repeat (20) drive_sample(8'd255);
    wait_drain();
    close_test();

    // reset with samples in flight
    start_test(4);
    for (int i = 0; i < 6; i++) begin
      drive_sample(sample_t'($random(seed)));
    end
    @(posedge clk);
    rstn     <= 1'b0;
    en       <= 1'b0;
    exp_push <= 1'b0;
    clear_history();
    repeat (8) @(posedge clk);
    rstn <= 1'b1;
    run_impulse();
    wait_drain();
    close_test();

    drive_idle(3);
    asrt_fails = fir_top_inst.fir_checker_inst.fail_count;
    $display("tests passed: %0d, failed: %0d, assertion failures: %0d",
             pass_cnt, fail_cnt, asrt_fails);
    if (fail_cnt == 0 && pass_cnt == n_tests && asrt_fails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
src/fir_pkg.sv
src/tap_delay_line.sv
src/mac_tap.sv
src/adder_tree.sv
src/fir_top.sv
verif/fir_checker.sv
verif/fir_scoreboard.sv
verif/fir_tb.sv

//--- run.sh
#!/bin/sh
# build and run the FIR testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module fir_tb -o fir_sim

# keep running past assertion errors so the testbench prints its verdict
./obj_dir/fir_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "^Test OK$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
